// ==== common/calc_defines.svh ====
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// accumulator and term width
`define CALC_WIDTH 32

// result digits out of the converter
`define BCD_DIGITS 10

`define NUM_DIGIT_KEYS 10

// double dabble adds three from this nibble value up
`define DABBLE_ADD_MIN 5

`endif

// ==== common/calc_pkg.sv ====
`default_nettype none

`include "calc_defines.svh"

package calc_pkg;

    typedef logic signed [`CALC_WIDTH-1:0]   calc_word_t;
    typedef logic [3:0]                      digit_t;
    typedef logic [`BCD_DIGITS*4-1:0]        bcd_word_t;
    typedef logic [7:0]                      seg_t;  // segments a..g plus dot

    typedef enum logic [1:0]
    {
        op_add,
        op_sub,
        op_mul,
        op_div
    } op_t;

    typedef enum logic [2:0]
    {
        st_idle,
        st_operand,
        st_operator,
        st_convert,
        st_result
    } core_state_t;

endpackage

`default_nettype wire

// ==== common/bcd_conv_if.sv ====
`default_nettype none

// four-phase req/ack between core and converter
interface bcd_conv_if;
    import calc_pkg::*;

    logic       req;
    calc_word_t value;     // two's complement result
    logic       ack;
    bcd_word_t  bcd;
    logic       negative;

    modport requester (
        output req,
        output value,
        input  ack,
        input  bcd,
        input  negative
    );

    modport converter (
        input  req,
        input  value,
        output ack,
        output bcd,
        output negative
    );
endinterface

`default_nettype wire

// ==== logic/key_decoder.sv ====
`default_nettype none

`include "calc_defines.svh"

module key_decoder (
    input  logic                       rst,
    input  logic                       clk_100hz,
    input  logic [`NUM_DIGIT_KEYS-1:0] digit_keys,
    input  logic [5:0]                 op_keys,
    output calc_pkg::seg_t             seg,
    output logic [7:0]                 led,
    output logic                       digit_press,
    output calc_pkg::digit_t           digit_val,
    output logic                       op_press,
    output calc_pkg::op_t              op_val,
    output logic                       neg_press,
    output logic                       equ_press
);
    import calc_pkg::*;

    localparam int GROUPS = 3;  // operand, operator, equals

    digit_t            digit_sel;
    seg_t              seg_sel;
    op_t               op_sel;
    logic              operand_is_neg;
    logic [GROUPS-1:0] group_held;
    logic [GROUPS-1:0] group_pulse;

    // key 1 wins over 2 and so on, key 0 last
    always_comb
    begin
        digit_sel = '0;
        for (int i = `NUM_DIGIT_KEYS - 1; i > 0; i--)
        begin
            if (digit_keys[i])
                digit_sel = digit_t'(i);
        end
    end

    always_comb
    begin
        case (digit_sel)
            4'd1:    seg_sel = 8'b0110_0000;
            4'd2:    seg_sel = 8'b1101_1010;
            4'd3:    seg_sel = 8'b1111_0010;
            4'd4:    seg_sel = 8'b0110_0110;
            4'd5:    seg_sel = 8'b1011_0110;
            4'd6:    seg_sel = 8'b1011_1110;
            4'd7:    seg_sel = 8'b1110_0000;
            4'd8:    seg_sel = 8'b1111_1110;
            4'd9:    seg_sel = 8'b1111_0110;
            default: seg_sel = 8'b1111_1100;
        endcase
    end

    always_comb
    begin
        if (op_keys[1])
            op_sel = op_add;
        else if (op_keys[2])
            op_sel = op_sub;
        else if (op_keys[3])
            op_sel = op_mul;
        else
            op_sel = op_div;
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            seg            <= '0;
            digit_val      <= '0;
            operand_is_neg <= 1'b0;
        end
        else if (|digit_keys)
        begin
            seg            <= seg_sel;
            digit_val      <= digit_sel;
            operand_is_neg <= 1'b0;
        end
        else if (op_keys[0])
            operand_is_neg <= 1'b1;  // negate shares the operand group
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            led    <= '0;
            op_val <= op_add;
        end
        else
        begin
            if (|op_keys[4:1])
                op_val <= op_sel;
            if (op_keys[0])
                led <= 8'b1000_0000;
            else if (op_keys[1])
                led <= 8'b0100_0000;
            else if (op_keys[2])
                led <= 8'b0010_0000;
            else if (op_keys[3])
                led <= 8'b0001_0000;
            else if (op_keys[4])
                led <= 8'b0000_1000;
            else if (op_keys[5])
                led <= 8'b0000_0001;
        end
    end

    assign group_held = {op_keys[5], |op_keys[4:1], (|digit_keys) | op_keys[0]};

    // one press per hold, registered so the pulse lands on the second edge
    for (genvar g = 0; g < GROUPS; g++)
    begin : g_edge
        logic [1:0] hist;
        logic       pulse;

        always_ff @(posedge rst or posedge clk_100hz)
        begin
            if (clk_100hz)
            begin
                hist  <= '0;
                pulse <= 1'b0;
            end
            else
            begin
                hist  <= {hist[0], group_held[g]};
                pulse <= hist[0] & ~hist[1];
            end
        end

        assign group_pulse[g] = pulse;
    end

    assign digit_press = group_pulse[0] & ~operand_is_neg;
    assign neg_press   = group_pulse[0] & operand_is_neg;
    assign op_press    = group_pulse[1];
    assign equ_press   = group_pulse[2];

endmodule

`default_nettype wire

// ==== calc/calc_core.sv ====
`default_nettype none

module calc_core (
    input  logic             rst,
    input  logic             clk_100hz,
    input  logic             digit_press,
    input  calc_pkg::digit_t digit_val,
    input  logic             op_press,
    input  calc_pkg::op_t    op_val,
    input  logic             neg_press,
    input  logic             equ_press,
    bcd_conv_if.requester    conv,
    output logic             result_valid
);
    import calc_pkg::*;

    core_state_t state;
    calc_word_t  acc;
    calc_word_t  term_mag;
    calc_word_t  term;
    calc_word_t  folded;
    op_t         pend_op;
    logic        term_neg;

    // strictly left to right, no precedence
    function automatic calc_word_t apply_op(calc_word_t lhs, calc_word_t rhs, op_t op);
        calc_word_t res;
        case (op)
            op_add:  res = lhs + rhs;
            op_sub:  res = lhs - rhs;
            op_mul:  res = lhs * rhs;  // low word only
            default:
            begin
                if (rhs == '0)
                    res = '0;
                else
                    res = lhs / rhs;  // signed, truncates toward zero
            end
        endcase
        return res;
    endfunction

    assign term   = term_neg ? -term_mag : term_mag;
    assign folded = apply_op(acc, term, pend_op);

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            state        <= st_idle;
            acc          <= '0;
            term_mag     <= '0;
            term_neg     <= 1'b0;
            pend_op      <= op_add;
            conv.req     <= 1'b0;
            conv.value   <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle, st_operand, st_operator:
                begin
                    if (digit_press)
                    begin
                        term_mag <= term_mag * 10 + calc_word_t'(digit_val);
                        state    <= st_operand;
                    end
                    else if (neg_press)
                    begin
                        term_neg <= 1'b1;
                        state    <= st_operand;
                    end
                    else if (op_press && state == st_operand)
                    begin
                        acc      <= folded;
                        pend_op  <= op_val;
                        term_mag <= '0;
                        term_neg <= 1'b0;
                        state    <= st_operator;
                    end
                    else if (equ_press && state == st_operand)
                    begin
                        acc        <= folded;
                        term_mag   <= '0;
                        term_neg   <= 1'b0;
                        conv.value <= folded;
                        conv.req   <= 1'b1;
                        state      <= st_convert;
                    end
                end
                st_convert:
                begin
                    if (conv.ack)
                    begin
                        conv.req     <= 1'b0;
                        result_valid <= 1'b1;
                        state        <= st_result;
                    end
                end
                st_result:
                begin
                    // next digit opens a fresh calculation
                    if (digit_press)
                    begin
                        acc          <= '0;
                        pend_op      <= op_add;
                        term_mag     <= calc_word_t'(digit_val);
                        term_neg     <= 1'b0;
                        result_valid <= 1'b0;
                        state        <= st_operand;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== calc/bcd_converter.sv ====
`default_nettype none

`include "calc_defines.svh"

module bcd_converter (
    input  logic          rst,
    input  logic          clk_100hz,
    bcd_conv_if.converter conv
);
    import calc_pkg::*;

    localparam int STEP_W    = $clog2(`CALC_WIDTH);
    localparam int LAST_STEP = `CALC_WIDTH - 1;

    logic              busy;
    logic              start;
    logic [STEP_W-1:0] step;
    calc_word_t        mag;
    bcd_word_t         bcd_adj;

    assign start = ~busy & ~conv.ack & conv.req;

    // add three to every nibble about to overflow past 9
    always_comb
    begin
        bcd_adj = conv.bcd;
        for (int d = 0; d < `BCD_DIGITS; d++)
        begin
            if (conv.bcd[4*d +: 4] >= `DABBLE_ADD_MIN)
                bcd_adj[4*d +: 4] = conv.bcd[4*d +: 4] + 4'd3;
        end
    end

    always_ff @(posedge rst)
    begin
        if (start)
            mag <= conv.value[`CALC_WIDTH-1] ? -conv.value : conv.value;
        else if (busy)
            mag <= mag << 1;
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            busy          <= 1'b0;
            step          <= '0;
            conv.ack      <= 1'b0;
            conv.bcd      <= '0;
            conv.negative <= 1'b0;
        end
        else if (busy)
        begin
            conv.bcd <= {bcd_adj[$bits(bcd_word_t)-2:0], mag[`CALC_WIDTH-1]};
            step     <= step + 1'b1;
            if (step == LAST_STEP[STEP_W-1:0])
            begin
                busy     <= 1'b0;
                conv.ack <= 1'b1;  // digits final
            end
        end
        else if (conv.ack)
        begin
            if (!conv.req)
                conv.ack <= 1'b0;
        end
        else if (start)
        begin
            busy          <= 1'b1;
            step          <= '0;
            conv.bcd      <= '0;
            conv.negative <= conv.value[`CALC_WIDTH-1];
        end
    end

endmodule

`default_nettype wire

// ==== logic/calc_top.sv ====
`default_nettype none

`include "calc_defines.svh"

module calc_top (
    input  logic                       rst,
    input  logic                       clk_100hz,
    input  logic [`NUM_DIGIT_KEYS-1:0] digit_keys,
    input  logic [5:0]                 op_keys,
    output calc_pkg::seg_t             seg,
    output logic [7:0]                 led,
    output calc_pkg::bcd_word_t        result_bcd,
    output logic                       result_neg,
    output logic                       result_valid
);
    import calc_pkg::*;

    logic   digit_press;
    digit_t digit_val;
    logic   op_press;
    op_t    op_val;
    logic   neg_press;
    logic   equ_press;

    bcd_conv_if conv ();

    key_decoder u_keys (
        .rst         (rst),
        .clk_100hz   (clk_100hz),
        .digit_keys  (digit_keys),
        .op_keys     (op_keys),
        .seg         (seg),
        .led         (led),
        .digit_press (digit_press),
        .digit_val   (digit_val),
        .op_press    (op_press),
        .op_val      (op_val),
        .neg_press   (neg_press),
        .equ_press   (equ_press)
    );

    calc_core u_core (
        .rst          (rst),
        .clk_100hz    (clk_100hz),
        .digit_press  (digit_press),
        .digit_val    (digit_val),
        .op_press     (op_press),
        .op_val       (op_val),
        .neg_press    (neg_press),
        .equ_press    (equ_press),
        .conv         (conv.requester),
        .result_valid (result_valid)
    );

    bcd_converter u_conv (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .conv      (conv.converter)
    );

    // converter holds these until the next request
    assign result_bcd = conv.bcd;
    assign result_neg = conv.negative;

endmodule

`default_nettype wire

// ==== verif/calc_tb.sv ====
`default_nettype none

`include "calc_defines.svh"

module calc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import calc_pkg::*;

    logic                       rst;  // clock
    logic                       clk_100hz;  // reset
    logic [`NUM_DIGIT_KEYS-1:0] digit_keys;
    logic [5:0]                 op_keys;
    seg_t                       seg;
    logic [7:0]                 led;
    bcd_word_t                  result_bcd;
    logic                       result_neg;
    logic                       result_valid;

    // one entry per vector line
    byte         kinds[$];
    logic [39:0] arg_a[$];
    logic [39:0] arg_b[$];
    int          cycle_count = 0;
    int          cycle_limit = 0;

    calc_top uut (
        .rst          (rst),
        .clk_100hz    (clk_100hz),
        .digit_keys   (digit_keys),
        .op_keys      (op_keys),
        .seg          (seg),
        .led          (led),
        .result_bcd   (result_bcd),
        .result_neg   (result_neg),
        .result_valid (result_valid)
    );

    initial
    begin
        rst = 1'b0;
        forever #5 rst = ~rst;
    end

    always @(posedge rst)
    begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
        begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic compare_value(
        input string       what,
        input logic [39:0] got,
        input logic [39:0] want
    );
        assert (got === want)
        else
        begin
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, want);
            $display("Result: FAILED");
            $fatal(1, "%s check failed", what);
        end
    endtask

    // press on a falling edge, hold a random while, then release
    task automatic tap_keys(input logic [`NUM_DIGIT_KEYS-1:0] dmask, input logic [5:0] omask);
        int hold;
        hold = int'($urandom_range(6, 2));
        @(negedge rst);
        digit_keys = dmask;
        op_keys    = omask;
        repeat (hold) @(negedge rst);
        digit_keys = '0;
        op_keys    = '0;
        repeat (3) @(negedge rst);  // group released long enough
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [39:0] a;
        logic [39:0] b;
        fd = $fopen("verif/calc_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the vector file verif/calc_vectors.txt");
            $display("Result: FAILED");
            $fatal(1, "missing vectors");
        end
        while ($fgets(line, fd) != 0)
        begin
            kind = line.getc(0);
            if (kind == "d" || kind == "o" || kind == "w")
            begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                if (n != 2)
                begin
                    $display("Vector line is malformed: %s", line);
                    $display("Result: FAILED");
                    $fatal(1, "bad vector line");
                end
                kinds.push_back(kind);
                arg_a.push_back(a);
                arg_b.push_back(b);
            end
        end
        $fclose(fd);
    endtask

    initial
    begin
        void'($urandom(18542));
        clk_100hz  = 1'b1;
        digit_keys = '0;
        op_keys    = '0;
        load_vectors();
        cycle_limit = kinds.size() * 80;

        repeat (8) @(negedge rst);
        clk_100hz = 1'b0;
        repeat (2) @(negedge rst);
        compare_value("seg after reset", 40'(seg), 40'h0);
        compare_value("led after reset", 40'(led), 40'h0);
        compare_value("result_valid after reset", 40'(result_valid), 40'h0);

        for (int i = 0; i < kinds.size(); i++)
        begin
            case (kinds[i])
                "d":
                begin
                    tap_keys(arg_a[i][`NUM_DIGIT_KEYS-1:0], 6'b0);
                    compare_value("seg", 40'(seg), arg_b[i]);
                end
                "o":
                begin
                    tap_keys('0, arg_a[i][5:0]);
                    compare_value("led", 40'(led), arg_b[i]);
                end
                default:
                begin
                    while (result_valid !== 1'b1)
                        @(negedge rst);
                    compare_value("result_neg", 40'(result_neg), arg_a[i]);
                    compare_value("result_bcd", 40'(result_bcd), arg_b[i]);
                end
            endcase
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/calc_vectors.txt ====
# d <digit key mask> <seg> | o <op key mask neg,add,sub,mul,div,equ from bit 0> <led>
# w <result sign> <ten BCD digits>
d 002 60
d 004 DA
d 008 F2
o 02 40
d 010 66
d 020 B6
o 04 20
d 040 BE
o 20 01
w 0 0000000162
d 200 F6
o 04 20
d 004 DA
d 001 FC
o 20 01
w 1 0000000011
d 004 DA
o 02 40
d 008 F2
o 08 10
d 010 66
o 20 01
w 0 0000000020
d 300 FE
d 081 E0
o 10 08
o 01 80
d 010 66
o 20 01
w 1 0000000021
d 020 B6
o 02 40
o 08 10
d 008 F2
o 20 01
w 0 0000000008
d 040 BE
o 10 08
d 001 FC
o 20 01
w 0 0000000000

// ==== filelist.f ====
+incdir+common
common/calc_pkg.sv
common/bcd_conv_if.sv
logic/key_decoder.sv
calc/calc_core.sv
calc/bcd_converter.sv
logic/calc_top.sv
verif/calc_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = calc_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(BUILD_DIR)
